//--- logic/alu_pkg.sv
// Shared types for the pipelined RISC-V execute unit.
// Import into module bodies; use scoped names in port lists.

package alu_pkg;

  //////////////////////////////////////////////////
  // Data widths
  //////////////////////////////////////////////////

  // One machine word
  typedef logic [31:0] word_t;

  // Shift amount, low five bits of operand b
  typedef logic [4:0] shamt_t;

  //////////////////////////////////////////////////
  // Operation encoding
  //////////////////////////////////////////////////

  // 36 operations need six bits
  typedef enum logic [5:0] {
    // Adder
    ALU_ADD,
    ALU_SUB,
    // Plain and negated bitwise
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_ANDN,
    ALU_ORN,
    ALU_XNOR,
    // Shifts and rotates
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_ROL,
    ALU_ROR,
    // Single-bit operations
    ALU_BSET, ALU_BCLR, ALU_BINV, ALU_BEXT,
    // Shift then add
    ALU_SH1ADD, ALU_SH2ADD, ALU_SH3ADD,
    // Set-less-than and min/max
    ALU_SLT, ALU_SLTU,
    ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU,
    // Branch comparisons
    ALU_EQ, ALU_NE, ALU_LT, ALU_LTU, ALU_GE, ALU_GEU,
    // Sign extension and byte operations
    ALU_SEXT_B, ALU_SEXT_H, ALU_REV8, ALU_ORC_B
  } alu_op_e;

  //////////////////////////////////////////////////
  // Request bundle
  //////////////////////////////////////////////////

  // Operation plus both source operands
  typedef struct packed {
    alu_op_e op;
    word_t   operand_a;
    word_t   operand_b;
  } alu_req_t;

endpackage

//--- logic/alu_shifter.sv
// Rotate-based shifter for shifts, rotates and single-bit operations.
// Combinational; takes the whole request and returns one result word.

`timescale 1ns/100ps

module alu_shifter (
  input  alu_pkg::alu_req_t req_i,
  output alu_pkg::word_t    shift_o
);
  import alu_pkg::*;

  //////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////

  logic        rotate;
  logic        rshift;
  logic        arithmetic;
  // Forces the low word to 1 to build a single-bit mask
  logic        tieoff;
  shamt_t      shamt;
  logic [5:0]  rot_amt;
  word_t       low_word;
  word_t       fill_word;
  logic [63:0] rot_tmp;
  word_t       rot_result;

  assign shamt = req_i.operand_b[4:0];

  // Rotates reuse the arithmetic path with operand a as fill
  assign rotate     = (req_i.op inside {ALU_ROL, ALU_ROR});
  assign arithmetic = (req_i.op inside {ALU_SRA, ALU_ROL, ALU_ROR});
  // BEXT shifts operand a down and keeps bit zero
  assign rshift     = (req_i.op inside {ALU_SRL, ALU_SRA, ALU_ROR, ALU_BEXT});
  assign tieoff     = (req_i.op inside {ALU_BSET, ALU_BCLR, ALU_BINV});

  always_comb begin
    low_word = tieoff ? 32'h1 : req_i.operand_a;
    // Right shift is a left rotate by 64 minus the amount
    rot_amt  = {1'b0, shamt};
    if (rshift) begin
      rot_amt = -rot_amt;
    end
    // Upper half supplies the bits shifted into the result
    if (arithmetic) begin
      fill_word = rotate ? req_i.operand_a : {32{req_i.operand_a[31]}};
    end else begin
      // Logical shifts and single-bit masks bring in zeros
      fill_word = '0;
    end
  end

  //////////////////////////////////////////////////
  // 64-bit left rotator, six binary stages
  //////////////////////////////////////////////////

  always_comb begin
    rot_tmp = {fill_word, low_word};
    rot_tmp = rot_amt[5] ? {rot_tmp[31:0], rot_tmp[63:32]} : rot_tmp;
    rot_tmp = rot_amt[4] ? {rot_tmp[47:0], rot_tmp[63:48]} : rot_tmp;
    rot_tmp = rot_amt[3] ? {rot_tmp[55:0], rot_tmp[63:56]} : rot_tmp;
    rot_tmp = rot_amt[2] ? {rot_tmp[59:0], rot_tmp[63:60]} : rot_tmp;
    rot_tmp = rot_amt[1] ? {rot_tmp[61:0], rot_tmp[63:62]} : rot_tmp;
    rot_tmp = rot_amt[0] ? {rot_tmp[62:0], rot_tmp[63]} : rot_tmp;
  end

  assign rot_result = rot_tmp[31:0];

  // Single-bit operations apply the rotated mask to operand a
  always_comb begin
    case (req_i.op)
      ALU_BSET: shift_o = req_i.operand_a | rot_result;
      ALU_BCLR: shift_o = req_i.operand_a & ~rot_result;
      ALU_BINV: shift_o = req_i.operand_a ^ rot_result;
      ALU_BEXT: shift_o = rot_result & 32'h1;
      default:  shift_o = rot_result;
    endcase
  end

  // Plain left shift leaves only zeros in the vacated low bits
  always_comb begin
    assert final ((req_i.op != ALU_SLL) ||
                  ((shift_o & ((32'h1 << shamt) - 32'h1)) == '0))
      else $error("alu_shifter: SLL filled vacated low bits with ones");
  end

endmodule

//--- logic/alu_adder.sv
// Adder datapath for ADD, SUB and the SHxADD family.
// Combinational; operand a is pre-shifted for the shift-then-add forms.

`timescale 1ns/100ps

module alu_adder (
  input  alu_pkg::alu_req_t req_i,
  output alu_pkg::word_t    sum_o
);
  import alu_pkg::*;

  logic  sub_op;
  word_t add_a;
  word_t add_b;

  //////////////////////////////////////////////////
  // Operand preparation
  //////////////////////////////////////////////////

  assign sub_op = (req_i.op == ALU_SUB);

  // Scale operand a for SH1ADD..SH3ADD
  always_comb begin
    case (req_i.op)
      ALU_SH1ADD: add_a = {req_i.operand_a[30:0], 1'b0};
      ALU_SH2ADD: add_a = {req_i.operand_a[29:0], 2'b0};
      ALU_SH3ADD: add_a = {req_i.operand_a[28:0], 3'b0};
      default:    add_a = req_i.operand_a;
    endcase
  end

  // Two's complement subtract: invert b, carry in one
  assign add_b = sub_op ? ~req_i.operand_b : req_i.operand_b;

  //////////////////////////////////////////////////
  // Carry chain
  //////////////////////////////////////////////////

  assign sum_o = add_a + add_b + {31'b0, sub_op};

endmodule

//--- logic/alu_compare.sv
// Shared comparator for branches, SLT/SLTU and MIN/MAX variants.
// Combinational; gives the compare bit and the selected min/max word.

`timescale 1ns/100ps

module alu_compare (
  input  alu_pkg::alu_req_t req_i,
  output logic              cmp_o,
  output alu_pkg::word_t    minmax_o
);
  import alu_pkg::*;

  logic cmp_signed;
  logic is_equal;
  // One comparator for both signed and unsigned forms
  logic is_greater;

  //////////////////////////////////////////////////
  // Magnitude and equality
  //////////////////////////////////////////////////

  assign cmp_signed = (req_i.op inside {ALU_LT, ALU_GE, ALU_SLT, ALU_MIN, ALU_MAX});
  assign is_equal   = (req_i.operand_a == req_i.operand_b);

  // Extra top bit carries the sign only for signed forms
  assign is_greater =
    $signed({req_i.operand_a[31] & cmp_signed, req_i.operand_a}) >
    $signed({req_i.operand_b[31] & cmp_signed, req_i.operand_b});

  //////////////////////////////////////////////////
  // Compare bit
  //////////////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      ALU_EQ:           cmp_o = is_equal;
      ALU_NE:           cmp_o = ~is_equal;
      ALU_GE, ALU_GEU:  cmp_o = is_greater | is_equal;
      // Less-than for LT/LTU/SLT/SLTU and masked later otherwise
      default:          cmp_o = ~(is_greater | is_equal);
    endcase
  end

  // MIN takes a unless a is larger; MAX the reverse
  always_comb begin
    if (req_i.op inside {ALU_MAX, ALU_MAXU}) begin
      minmax_o = is_greater ? req_i.operand_a : req_i.operand_b;
    end else begin
      minmax_o = is_greater ? req_i.operand_b : req_i.operand_a;
    end
  end

  // Unsigned min/max never lies outside the operand pair
  always_comb begin
    assert final (!(req_i.op inside {ALU_MINU, ALU_MAXU}) ||
                  ((req_i.op == ALU_MINU) ?
                   ((minmax_o <= req_i.operand_a) && (minmax_o <= req_i.operand_b)) :
                   ((minmax_o >= req_i.operand_a) && (minmax_o >= req_i.operand_b))))
      else $error("alu_compare: unsigned min/max result out of order");
  end

endmodule

//--- logic/alu_result_stage.sv
// Final result selection and the single output register stage.
// Adds the local bitwise and byte operations, then registers valid and result.

`timescale 1ns/100ps

module alu_result_stage (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              valid_i,
  input  alu_pkg::alu_req_t req_i,
  input  alu_pkg::word_t    shift_i,
  input  alu_pkg::word_t    sum_i,
  input  alu_pkg::word_t    minmax_i,
  input  logic              cmp_i,
  output logic              valid_o,
  output alu_pkg::word_t    result_o,
  output logic              cmp_o
);
  import alu_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t orc_b;
  word_t result_d;
  logic  is_cmp_op;
  logic  cmp_d;

  assign op_a = req_i.operand_a;
  assign op_b = req_i.operand_b;

  // Each byte becomes all ones if any bit in it is set
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      orc_b[i*8 +: 8] = {8{|op_a[i*8 +: 8]}};
    end
  end

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      ALU_ADD, ALU_SUB,
      ALU_SH1ADD, ALU_SH2ADD, ALU_SH3ADD: result_d = sum_i;
      ALU_AND:    result_d = op_a & op_b;
      ALU_OR:     result_d = op_a | op_b;
      ALU_XOR:    result_d = op_a ^ op_b;
      ALU_ANDN:   result_d = op_a & ~op_b;
      ALU_ORN:    result_d = op_a | ~op_b;
      ALU_XNOR:   result_d = ~(op_a ^ op_b);
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROL, ALU_ROR,
      ALU_BSET, ALU_BCLR, ALU_BINV, ALU_BEXT: result_d = shift_i;
      ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU:   result_d = minmax_i;
      ALU_SLT, ALU_SLTU: result_d = {31'b0, cmp_i};
      ALU_SEXT_B: result_d = {{24{op_a[7]}}, op_a[7:0]};
      ALU_SEXT_H: result_d = {{16{op_a[15]}}, op_a[15:0]};
      ALU_REV8:   result_d = {op_a[7:0], op_a[15:8], op_a[23:16], op_a[31:24]};
      ALU_ORC_B:  result_d = orc_b;
      // Branch compares report through cmp only
      default:    result_d = '0;
    endcase
  end

  // Compare bit only leaves for branch and set-less-than ops
  assign is_cmp_op = (req_i.op inside {ALU_EQ, ALU_NE, ALU_LT, ALU_LTU, ALU_GE, ALU_GEU,
                                       ALU_SLT, ALU_SLTU});
  assign cmp_d     = is_cmp_op & cmp_i;

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      cmp_o    <= 1'b0;
    end else begin
      valid_o <= valid_i;
      // Outputs hold through idle cycles
      if (valid_i) begin
        result_o <= result_d;
        cmp_o    <= cmp_d;
      end
    end
  end

  // Set-less-than word and compare bit leave together
  assert property (@(posedge clk) disable iff (rst_i)
                   (valid_i && (req_i.op inside {ALU_SLT, ALU_SLTU}))
                   |=> (result_o == {31'b0, cmp_o}))
    else $error("alu_result_stage: SLT word and compare bit disagree");

  // Branch compares leave a zero word
  assert property (@(posedge clk) disable iff (rst_i)
                   (valid_i && (req_i.op inside {ALU_EQ, ALU_NE, ALU_LT, ALU_LTU,
                                                 ALU_GE, ALU_GEU}))
                   |=> (result_o == '0))
    else $error("alu_result_stage: branch compare gave a nonzero word");

endmodule

//--- logic/alu_top.sv
// Top of the one-stage pipelined execute unit.
// Feeds the request to three combinational datapaths and one register stage.

`timescale 1ns/100ps

module alu_top (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              valid_i,
  input  alu_pkg::alu_req_t req_i,
  output logic              valid_o,
  output alu_pkg::word_t    result_o,
  output logic              cmp_o
);
  import alu_pkg::*;

  word_t shift_w;
  word_t sum_w;
  word_t minmax_w;
  logic  cmp_w;

  //////////////////////////////////////////////////
  // Datapaths, all combinational
  //////////////////////////////////////////////////

  alu_shifter u_shifter (
    .req_i   (req_i),
    .shift_o (shift_w)
  );

  alu_adder u_adder (
    .req_i (req_i),
    .sum_o (sum_w)
  );

  alu_compare u_compare (
    .req_i    (req_i),
    .cmp_o    (cmp_w),
    .minmax_o (minmax_w)
  );

  // Selection and the only register stage
  alu_result_stage u_result_stage (
    .clk      (clk),
    .rst_i    (rst_i),
    .valid_i  (valid_i),
    .req_i    (req_i),
    .shift_i  (shift_w),
    .sum_i    (sum_w),
    .minmax_i (minmax_w),
    .cmp_i    (cmp_w),
    .valid_o  (valid_o),
    .result_o (result_o),
    .cmp_o    (cmp_o)
  );

endmodule

//--- test/alu_ref.svh
// Reference model of the execute unit, written straight from the ISA rules.
// Included inside the testbench module after alu_pkg is imported.

`ifndef ALU_REF_SVH
`define ALU_REF_SVH

// Expected result word and compare bit for one request
typedef struct packed {
  word_t result;
  logic  cmp;
} expect_t;

function automatic expect_t expected_result(input alu_req_t req);
  word_t   a;
  word_t   b;
  shamt_t  sh;
  expect_t e;
  a = req.operand_a;
  b = req.operand_b;
  // Only the low five bits of b count as an amount
  sh = b[4:0];
  e  = '0;
  case (req.op)
    ALU_ADD:    e.result = a + b;
    ALU_SUB:    e.result = a - b;
    ALU_SH1ADD: e.result = (a << 1) + b;
    ALU_SH2ADD: e.result = (a << 2) + b;
    ALU_SH3ADD: e.result = (a << 3) + b;
    ALU_AND:    e.result = a & b;
    ALU_OR:     e.result = a | b;
    ALU_XOR:    e.result = a ^ b;
    ALU_ANDN:   e.result = a & ~b;
    ALU_ORN:    e.result = a | ~b;
    ALU_XNOR:   e.result = ~(a ^ b);
    ALU_SLL:    e.result = a << sh;
    ALU_SRL:    e.result = a >> sh;
    ALU_SRA:    e.result = $signed(a) >>> sh;
    // A shift by 32 gives zero, so amount 0 rotates cleanly
    ALU_ROL:    e.result = (a << sh) | (a >> (6'd32 - {1'b0, sh}));
    ALU_ROR:    e.result = (a >> sh) | (a << (6'd32 - {1'b0, sh}));
    ALU_BSET:   e.result = a | (32'h1 << sh);
    ALU_BCLR:   e.result = a & ~(32'h1 << sh);
    ALU_BINV:   e.result = a ^ (32'h1 << sh);
    ALU_BEXT:   e.result = {31'b0, a[sh]};
    ALU_MIN:    e.result = ($signed(a) < $signed(b)) ? a : b;
    ALU_MINU:   e.result = (a < b) ? a : b;
    ALU_MAX:    e.result = ($signed(a) > $signed(b)) ? a : b;
    ALU_MAXU:   e.result = (a > b) ? a : b;
    ALU_SEXT_B: e.result = {{24{a[7]}}, a[7:0]};
    ALU_SEXT_H: e.result = {{16{a[15]}}, a[15:0]};
    // Set-less-than returns the bit both ways
    ALU_SLT: begin
      e.cmp    = $signed(a) < $signed(b);
      e.result = {31'b0, e.cmp};
    end
    ALU_SLTU: begin
      e.cmp    = a < b;
      e.result = {31'b0, e.cmp};
    end
    // Branch compares leave the word at zero
    ALU_EQ:     e.cmp = (a == b);
    ALU_NE:     e.cmp = (a != b);
    ALU_LT:     e.cmp = $signed(a) < $signed(b);
    ALU_LTU:    e.cmp = a < b;
    ALU_GE:     e.cmp = $signed(a) >= $signed(b);
    ALU_GEU:    e.cmp = a >= b;
    ALU_REV8: begin
      for (int i = 0; i < 4; i++) begin
        e.result[i*8 +: 8] = a[(3-i)*8 +: 8];
      end
    end
    ALU_ORC_B: begin
      for (int i = 0; i < 4; i++) begin
        e.result[i*8 +: 8] = (a[i*8 +: 8] != 8'h00) ? 8'hff : 8'h00;
      end
    end
    default:    e = '0;
  endcase
  return e;
endfunction

`endif

//--- test/alu_tb.sv
// Testbench for the pipelined execute unit with directed corners, then random traffic.
// Expectations are queued at the input edge and drained when valid_o shows up.

`timescale 1ns/100ps

module alu_tb;
  import alu_pkg::*;

  `include "alu_ref.svh"

  localparam int          RANDOM_CYCLES  = 2000;
  // About 180 directed ops, reset and the random phase, plus margin
  localparam int          TIMEOUT_CYCLES = 2500;
  localparam int unsigned N_OPS          = 36;

  logic     clk = 1'b0;
  logic     rst_i;
  logic     valid_i;
  alu_req_t req_i;
  logic     valid_o;
  word_t    result_o;
  logic     cmp_o;

  integer   seed   = 32'h1994;
  int       cycles = 0;
  int       errors = 0;
  int       checks = 0;
  // One entry per accepted request, oldest first
  expect_t  exp_q[$];
  expect_t  last_exp = '0;

  alu_op_e  arith_ops[15] = '{ALU_ADD, ALU_SUB, ALU_SH1ADD, ALU_SH2ADD, ALU_SH3ADD,
                              ALU_AND, ALU_OR, ALU_XOR, ALU_ANDN, ALU_ORN, ALU_XNOR,
                              ALU_SEXT_B, ALU_SEXT_H, ALU_REV8, ALU_ORC_B};
  alu_op_e  shift_ops[9]  = '{ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROL, ALU_ROR,
                              ALU_BSET, ALU_BCLR, ALU_BINV, ALU_BEXT};
  alu_op_e  cmp_ops[12]   = '{ALU_EQ, ALU_NE, ALU_LT, ALU_LTU, ALU_GE, ALU_GEU,
                              ALU_SLT, ALU_SLTU, ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU};
  // Carry, overflow and sign corners
  word_t    corner_a[4]   = '{32'h0000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0080};
  word_t    corner_b[4]   = '{32'h0000_0000, 32'h0000_0001, 32'h0000_0001, 32'h8000_8000};

  alu_top dut (
    .clk      (clk),
    .rst_i    (rst_i),
    .valid_i  (valid_i),
    .req_i    (req_i),
    .valid_o  (valid_o),
    .result_o (result_o),
    .cmp_o    (cmp_o)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////

  function automatic alu_op_e random_op();
    int unsigned pick;
    pick = $unsigned($random(seed)) % N_OPS;
    return alu_op_e'(6'(pick));
  endfunction

  // One request driven just after the edge
  task automatic send_op(input alu_op_e op, input word_t a, input word_t b);
    @(posedge clk);
    #1;
    valid_i         = 1'b1;
    req_i.op        = op;
    req_i.operand_a = a;
    req_i.operand_b = b;
  endtask

  // Idle cycle with junk on req_i while the outputs hold
  task automatic idle_cycle();
    @(posedge clk);
    #1;
    valid_i         = 1'b0;
    req_i.op        = random_op();
    req_i.operand_a = $random(seed);
    req_i.operand_b = $random(seed);
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////

  initial begin
    word_t  a;
    word_t  b;
    shamt_t amt;
    rst_i   = 1'b1;
    valid_i = 1'b0;
    req_i   = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_i = 1'b0;
    // Arithmetic, bitwise and byte ops on corner pairs
    foreach (arith_ops[i]) begin
      foreach (corner_a[j]) begin
        send_op(arith_ops[i], corner_a[j], corner_b[j]);
      end
    end
    // Amounts 0, 1, 31 and random; upper bits of b are noise
    foreach (shift_ops[i]) begin
      for (int k = 0; k < 4; k++) begin
        amt = (k == 0) ? 5'd0 : (k == 1) ? 5'd1 : (k == 2) ? 5'd31 : shamt_t'($random(seed));
        b   = (word_t'($random(seed)) & 32'hffff_ffe0) | {27'b0, amt};
        send_op(shift_ops[i], 32'h8000_0001, b);
        send_op(shift_ops[i], 32'hc3a5_96f0, b);
      end
    end
    // Equal, sign-bit-only difference both ways, random
    foreach (cmp_ops[i]) begin
      a = $random(seed);
      send_op(cmp_ops[i], a, a);
      send_op(cmp_ops[i], 32'h8000_0005, 32'h0000_0005);
      send_op(cmp_ops[i], 32'h0000_0005, 32'h8000_0005);
      send_op(cmp_ops[i], $random(seed), $random(seed));
    end
    // Random traffic, valid on roughly 3 of 4 cycles
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      if (($random(seed) & 3) != 0) begin
        send_op(random_op(), $random(seed), $random(seed));
      end else begin
        idle_cycle();
      end
    end
    idle_cycle();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  ////////////////////////////////////////////////////
  // Monitor, checker and timeout
  ////////////////////////////////////////////////////

  // Inputs settle 1 ns after the edge, so the edge sees them stable
  always @(posedge clk) begin
    if (!rst_i && valid_i) begin
      exp_q.push_back(expected_result(req_i));
    end
  end

  // Outputs are sampled mid-cycle
  always @(negedge clk) begin
    expect_t head;
    if (rst_i) begin
      last_exp = '0;
      check_value("valid_o", 32'h0, {31'b0, valid_o});
      check_value("result_o", 32'h0, result_o);
      check_value("cmp_o", 32'h0, {31'b0, cmp_o});
    end else if (valid_o) begin
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("valid_o went high at %0t with no request outstanding", $time);
      end
      if (exp_q.size() != 0) begin
        head     = exp_q.pop_front();
        last_exp = head;
        check_value("result_o", head.result, result_o);
        check_value("cmp_o", {31'b0, head.cmp}, {31'b0, cmp_o});
      end
    end else begin
      assert (exp_q.size() == 0) else begin
        errors++;
        $display("valid_o missing at %0t one cycle after an accepted request", $time);
        head = exp_q.pop_front();
      end
      // Last result must hold through a gap
      check_value("result_o", last_exp.result, result_o);
      check_value("cmp_o", {31'b0, last_exp.cmp}, {31'b0, cmp_o});
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: simulation still running after %0d cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

endmodule

//--- list.f
logic/alu_pkg.sv
logic/alu_shifter.sv
logic/alu_adder.sv
logic/alu_compare.sv
logic/alu_result_stage.sv
logic/alu_top.sv
+incdir+test
test/alu_tb.sv

//--- Makefile
SIM      := verilator
TOP      := alu_tb
FILELIST := list.f
SIMFLAGS := --binary --timing --assert --top-module $(TOP)
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) test/alu_ref.svh

.PHONY: all run clean

all: run

# Rebuild only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then exit 1; fi
	@grep -q "No errors" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
